//--- tiny_cpu.f
+incdir+.
cpu_types_pkg.sv
bus_pkg.sv
fetch_unit.sv
instr_queue.sv
exec_unit.sv
tiny_cpu.sv
tiny_cpu_checker.sv
tb_tiny_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tiny_cpu
FILELIST  ?= tiny_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_tiny_cpu.sv
`timescale 1ns/1ps

module tb_tiny_cpu;

    localparam int TIMEOUT = 2000;
    localparam int NPROG   = 5;

    logic                 clock;
    logic                 arst_n;
    bus_pkg::axil_addr_t  ar;
    bus_pkg::axil_addr_t  aw;
    bus_pkg::axil_rdata_t r;
    bus_pkg::axil_wdata_t w;
    bus_pkg::axil_resp_t  b;
    logic                 arready;
    logic                 rready;
    logic                 awready;
    logic                 wready;
    logic                 bready;
    logic                 halted;

    logic [31:0] lcg_state = 32'hfe5e_02e5;
    logic [31:0] prog [64];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] first_addr;
    logic        seen_read;
    logic        active;
    logic        rd_busy;
    logic        wr_busy;
    int          errors;
    int          failed_tests;
    int          taken;
    int          not_taken;
    int          jumps;
    int          chk_seen;

    tiny_cpu tiny_cpu_inst
    (
        .clock   (clock),
        .arst_n  (arst_n),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .halted  (halted)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % n);
    endfunction

    // fields from msb: imm, high/low, dst, src b, src a, opcode
    function automatic logic [31:0] encode(input logic [5:0] op, input logic [2:0] a,
        input logic [2:0] bsel, input logic [2:0] d, input logic hl, input logic [15:0] imm);
        return {imm, hl, d, bsel, a, op};
    endfunction

    // inputs change 1 ns after the edge, outputs are stable there
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_word(input string name, input int idx, input logic [31:0] got,
        input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("Fail %0t: %s[%0d] got %h expected %h", $time, name, idx, got, exp);
            errors++;
        end
    endtask

    task automatic gen_program();
        logic [31:0] rnd;
        logic [2:0]  bsel;
        logic [15:0] hi;
        logic [15:0] lo;
        int          pick;
        // load-half pairs so that every register is known, some left at zero
        for (int k = 0; k < 8; k++)
        begin
            if (k == 0)
                hi = 16'h0;
            else if (k == 1)
                hi = 16'(lcg_next() >> 16) | 16'h0001;
            else
                hi = (rand_below(4) == 0) ? 16'h0 : 16'(lcg_next() >> 16);
            lo = (hi == 16'h0) ? 16'h0 : 16'(lcg_next() >> 16);
            prog[2*k]   = encode(6'd6, 3'd0, 3'd0, 3'(k), 1'b1, hi);
            prog[2*k+1] = encode(6'd6, 3'd0, 3'd0, 3'(k), 1'b0, lo);
        end
        // r0 is zero and r1 is not, so the first branch is taken and the second is not
        prog[16] = encode(6'd8, 3'd0, 3'd0, 3'd0, 1'b0, 16'd18);
        prog[17] = encode(6'd7, 3'd1, 3'd0, 3'd0, 1'b0, 16'h0100);
        prog[18] = encode(6'd8, 3'd1, 3'd0, 3'd0, 1'b0, 16'd20);
        prog[19] = encode(6'd7, 3'd1, 3'd0, 3'd0, 1'b0, 16'h0101);
        prog[20] = encode(6'd9, 3'd0, 3'd0, 3'd0, 1'b0, 16'd22);
        prog[21] = encode(6'd7, 3'd1, 3'd0, 3'd0, 1'b0, 16'h0102);
        for (int k = 22; k < 63; k++)
        begin
            rnd  = lcg_next();
            pick = rand_below(12);
            bsel = (rnd[10:9] == 2'b00) ? rnd[2:0] : rnd[5:3];
            case (pick)
                0, 1, 2, 3, 4: prog[k] = encode(6'(pick + 1), rnd[2:0], bsel, rnd[8:6], 1'b0,
                                                rnd[31:16]);
                5:       prog[k] = encode(6'd6, 3'd0, 3'd0, rnd[8:6], rnd[11], rnd[31:16]);
                6, 7:    prog[k] = encode(6'd7, rnd[2:0], 3'd0, 3'd0, 1'b0, rnd[31:16]);
                8:       prog[k] = encode(6'd8, rnd[2:0], 3'd0, 3'd0, 1'b0,
                                          16'(k + 1 + rand_below(63 - k)));
                9:       prog[k] = encode(6'd9, 3'd0, 3'd0, 3'd0, 1'b0,
                                          16'(k + 1 + rand_below(63 - k)));
                10:      prog[k] = 32'h0;
                default: prog[k] = encode(6'(11 + rnd[14:11]), rnd[2:0], bsel, rnd[8:6],
                                          1'b0, rnd[31:16]);
            endcase
        end
        prog[63] = encode(6'd10, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
    endtask

    // instruction-set model producing the expected store list
    task automatic run_model();
        logic [31:0] regs [8];
        logic [7:0]  flags;
        logic [31:0] iw;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] res;
        logic [15:0] imm;
        logic [5:0]  op;
        int          pc;
        exp_addr.delete();
        exp_data.delete();
        taken = 0;
        not_taken = 0;
        jumps = 0;
        flags = '0;
        for (int k = 0; k < 8; k++)
            regs[k] = '0;
        pc = 0;
        while (pc < 64)
        begin
            iw  = prog[pc];
            op  = iw[5:0];
            imm = iw[31:16];
            va  = regs[iw[8:6]];
            vb  = regs[iw[11:9]];
            pc++;
            if (op == 6'd10)
                break;
            if (op >= 6'd1 && op <= 6'd6)
            begin
                case (op)
                    6'd1:    res = va + vb;
                    6'd2:    res = va - vb;
                    6'd3:    res = va & vb;
                    6'd4:    res = va | vb;
                    6'd5:    res = va ^ vb;
                    default: res = iw[15] ? {imm, regs[iw[14:12]][15:0]}
                                          : {regs[iw[14:12]][31:16], imm};
                endcase
                regs[iw[14:12]]  = res;
                flags[iw[14:12]] = (res == 32'h0);
            end
            else if (op == 6'd7)
            begin
                exp_addr.push_back({14'h0, imm, 2'b00});
                exp_data.push_back(va);
            end
            else if (op == 6'd8 && flags[iw[8:6]])
            begin
                taken++;
                pc = int'(imm);
            end
            else if (op == 6'd8)
                not_taken++;
            else if (op == 6'd9)
            begin
                jumps++;
                pc = int'(imm);
            end
        end
    endtask

    task automatic serve_read();
        logic [31:0] addr;
        int          n;
        rd_busy = 1'b1;
        repeat (rand_below(4)) step();
        addr    = ar.addr;
        arready = 1'b1;
        step();
        arready = 1'b0;
        if (!seen_read)
        begin
            first_addr = addr;
            seen_read  = 1'b1;
        end
        repeat (rand_below(4)) step();
        // words past the program are nops
        r.data  = (addr[31:8] == '0) ? prog[addr[7:2]] : {addr[31:16] ^ addr[15:0], 16'h0};
        r.resp  = 2'b00;
        r.valid = 1'b1;
        n = 0;
        while (!rready)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                timeout_fail("rready");
        end
        step();
        r.valid = 1'b0;
        rd_busy = 1'b0;
    endtask

    task automatic serve_write();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        aw_done;
        logic        w_done;
        int          aw_wait;
        int          w_wait;
        int          n;
        wr_busy = 1'b1;
        addr    = '0;
        data    = '0;
        strb    = '0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        aw_wait = rand_below(4);
        w_wait  = rand_below(4);
        n = 0;
        // address and data ready have their own delays, so either may go first
        while (!aw_done || !w_done)
        begin
            awready = !aw_done && aw.valid && (n >= aw_wait);
            wready  = !w_done && w.valid && (n >= w_wait);
            if (awready)
                addr = aw.addr;
            if (wready)
            begin
                data = w.data;
                strb = w.strb;
            end
            step();
            aw_done = aw_done || awready;
            w_done  = w_done || wready;
            awready = 1'b0;
            wready  = 1'b0;
            n++;
            if (n > TIMEOUT)
                timeout_fail("write address and data transfers");
        end
        check_word("store_strb", got_addr.size(), {28'h0, strb}, 32'h0000_000f);
        repeat (rand_below(4)) step();
        b.valid = 1'b1;
        n = 0;
        while (!bready)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                timeout_fail("bready");
        end
        step();
        b.valid = 1'b0;
        assert (!halted)
        else
        begin
            $display("store completed while the core reports halted");
            errors++;
        end
        got_addr.push_back(addr);
        got_data.push_back(data);
        wr_busy = 1'b0;
    endtask

    initial
    begin
        forever
        begin
            step();
            if (active && ar.valid)
                serve_read();
        end
    end

    initial
    begin
        forever
        begin
            step();
            if (active && (aw.valid || w.valid))
                serve_write();
        end
    end

    task automatic apply_reset();
        arst_n  = 1'b0;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        r       = '0;
        b       = '0;
        repeat (4)
        begin
            step();
            assert (!ar.valid && !aw.valid && !w.valid && !halted && !rready && !bready)
            else
            begin
                $display("an output valid, ready or halted is high during reset");
                errors++;
            end
        end
        arst_n = 1'b1;
    endtask

    task automatic run_test(input int num);
        int n;
        int errs_before;
        int cnt;
        errs_before = errors;
        gen_program();
        run_model();
        got_addr.delete();
        got_data.delete();
        seen_read = 1'b0;
        apply_reset();
        active = 1'b1;
        n = 0;
        while (!halted)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                timeout_fail("halted");
        end
        // no write may start once halted
        repeat (10)
        begin
            step();
            assert (!aw.valid && !w.valid)
            else
            begin
                $display("write valid raised after halt");
                errors++;
            end
        end
        active = 1'b0;
        n = 0;
        while (rd_busy || wr_busy)
        begin
            step();
            n++;
            if (n > TIMEOUT)
                timeout_fail("bus responders to go idle");
        end
        assert (seen_read)
        else
        begin
            $display("no fetch was issued");
            errors++;
        end
        check_word("first_read_addr", 0, first_addr, 32'h0);
        check_word("store_count", 0, got_addr.size(), exp_addr.size());
        cnt = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < cnt; i++)
        begin
            check_word("store_addr", i, got_addr[i], exp_addr[i]);
            check_word("store_data", i, got_data[i], exp_data[i]);
        end
        if (tiny_cpu_inst.tiny_cpu_checker_inst.fail_count != chk_seen)
        begin
            $display("bus protocol assertions failed during test %0d", num);
            errors += tiny_cpu_inst.tiny_cpu_checker_inst.fail_count - chk_seen;
            chk_seen = tiny_cpu_inst.tiny_cpu_checker_inst.fail_count;
        end
        if (errors > errs_before)
            failed_tests++;
        $display("test %0d: %0d stores, %0d taken, %0d not taken, %0d jumps, %0d errors",
                 num, got_addr.size(), taken, not_taken, jumps, errors - errs_before);
    endtask

    initial
    begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        arready      = 1'b0;
        awready      = 1'b0;
        wready       = 1'b0;
        r            = '0;
        b            = '0;
        active       = 1'b0;
        rd_busy      = 1'b0;
        wr_busy      = 1'b0;
        seen_read    = 1'b0;
        first_addr   = '0;
        errors       = 0;
        failed_tests = 0;
        chk_seen     = 0;
        for (int t = 0; t < NPROG; t++)
            run_test(t);
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 NPROG, failed_tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tiny_cpu_checker.sv
`timescale 1ns/1ps

module tiny_cpu_checker
(
    input logic                 clock,
    input logic                 arst_n,
    input bus_pkg::axil_addr_t  ar,
    input logic                 arready,
    input bus_pkg::axil_rdata_t r,
    input logic                 rready,
    input bus_pkg::axil_addr_t  aw,
    input logic                 awready,
    input bus_pkg::axil_wdata_t w,
    input logic                 wready,
    input bus_pkg::axil_resp_t  b,
    input logic                 bready,
    input logic                 halted
);

    int fail_count = 0;

    // valid and payload hold until the transfer
    ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr))
    else
    begin
        $error("ar valid dropped");
        fail_count++;
    end

    aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr))
    else
    begin
        $error("aw valid dropped");
        fail_count++;
    end

    w_hold: assert property (@(posedge clock) disable iff (!arst_n)
        w.valid && !wready |=> w.valid && $stable(w.data))
    else
    begin
        $error("w valid dropped");
        fail_count++;
    end

    r_hold: assert property (@(posedge clock) disable iff (!arst_n)
        r.valid && !rready |=> r.valid)
    else
    begin
        $error("r valid dropped");
        fail_count++;
    end

    b_hold: assert property (@(posedge clock) disable iff (!arst_n)
        b.valid && !bready |=> b.valid)
    else
    begin
        $error("b valid dropped");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> !(ar.valid || aw.valid || w.valid || halted))
    else
    begin
        $error("valid in reset");
        fail_count++;
    end

endmodule

bind tiny_cpu tiny_cpu_checker tiny_cpu_checker_inst (.*);

//--- tiny_cpu.sv
`timescale 1ns/1ps

module tiny_cpu
(
    input  logic                 clock,
    input  logic                 arst_n,
    output bus_pkg::axil_addr_t  ar,
    input  logic                 arready,
    input  bus_pkg::axil_rdata_t r,
    output logic                 rready,
    output bus_pkg::axil_addr_t  aw,
    input  logic                 awready,
    output bus_pkg::axil_wdata_t w,
    input  logic                 wready,
    input  bus_pkg::axil_resp_t  b,
    output logic                 bready,
    output logic                 halted
);

    logic                 push;
    cpu_types_pkg::word_t push_word;
    logic                 full;
    logic                 pop;
    logic                 flush;
    logic                 empty;
    cpu_types_pkg::word_t head_word;
    logic                 redirect_valid;
    cpu_types_pkg::word_t redirect_pc;

    fetch_unit fetch_unit_inst
    (
        .clock          (clock),
        .arst_n         (arst_n),
        .ar             (ar),
        .arready        (arready),
        .r              (r),
        .rready         (rready),
        .push           (push),
        .push_word      (push_word),
        .full           (full),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    instr_queue instr_queue_inst
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .flush     (flush),
        .head_word (head_word),
        .full      (full),
        .empty     (empty)
    );

    exec_unit exec_unit_inst
    (
        .clock          (clock),
        .arst_n         (arst_n),
        .head_word      (head_word),
        .empty          (empty),
        .pop            (pop),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .aw             (aw),
        .awready        (awready),
        .w              (w),
        .wready         (wready),
        .b              (b),
        .bready         (bready),
        .halted         (halted)
    );

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps
`include "tiny_cpu_cfg.svh"

module exec_unit
(
    input  logic                 clock,
    input  logic                 arst_n,
    input  cpu_types_pkg::word_t head_word,
    input  logic                 empty,
    output logic                 pop,
    output logic                 flush,
    output logic                 redirect_valid,
    output cpu_types_pkg::word_t redirect_pc,
    output bus_pkg::axil_addr_t  aw,
    input  logic                 awready,
    output bus_pkg::axil_wdata_t w,
    input  logic                 wready,
    input  bus_pkg::axil_resp_t  b,
    output logic                 bready,
    output logic                 halted
);

    cpu_types_pkg::exec_state_e state;
    cpu_types_pkg::instr_t      instr;
    cpu_types_pkg::word_t       regs [`TINY_CPU_NREGS];
    logic [`TINY_CPU_NREGS-1:0] flags;
    cpu_types_pkg::word_t       src_a;
    cpu_types_pkg::word_t       src_b;
    cpu_types_pkg::word_t       result;
    cpu_types_pkg::word_t       store_addr;
    cpu_types_pkg::word_t       store_data;
    logic                       write_en;
    logic                       is_store;
    logic                       aw_valid;
    logic                       w_valid;
    logic                       aw_left;
    logic                       w_left;

    assign instr = cpu_types_pkg::instr_t'(head_word);
    assign src_a = regs[instr.srca];
    assign src_b = regs[instr.srcb];

    assign pop      = (state == cpu_types_pkg::run) && !empty;
    assign is_store = pop && (instr.opcode == cpu_types_pkg::op_store);
    // opcodes 1 to 6 write their destination
    assign write_en = pop && (instr.opcode >= cpu_types_pkg::op_add)
                          && (instr.opcode <= cpu_types_pkg::op_ldh);

    // branch tests the flag of source a
    assign flush = pop && ((instr.opcode == cpu_types_pkg::op_jump)
                       || ((instr.opcode == cpu_types_pkg::op_branch) && flags[instr.srca]));
    assign redirect_valid = flush;
    assign redirect_pc    = cpu_types_pkg::word_t'(instr.value);

    always_comb
    begin
        result = regs[instr.dst];
        case (instr.opcode)
            cpu_types_pkg::op_add: result = src_a + src_b;
            cpu_types_pkg::op_sub: result = src_a - src_b;
            cpu_types_pkg::op_and: result = src_a & src_b;
            cpu_types_pkg::op_or:  result = src_a | src_b;
            cpu_types_pkg::op_xor: result = src_a ^ src_b;
            cpu_types_pkg::op_ldh:
            begin
                if (instr.highlow)
                    result = {instr.value, regs[instr.dst][15:0]};
                else
                    result = {regs[instr.dst][`TINY_CPU_XLEN-1:16], instr.value};
            end
            default: result = regs[instr.dst];
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `TINY_CPU_NREGS; i++)
                regs[i] <= '0;
            flags <= '0;
        end
        else if (write_en)
        begin
            regs[instr.dst]  <= result;
            flags[instr.dst] <= (result == '0);
        end
    end

    // address and data channels complete independently
    assign aw_left = aw_valid && !awready;
    assign w_left  = w_valid && !wready;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= cpu_types_pkg::idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end
        else
        begin
            case (state)
                cpu_types_pkg::idle:
                    state <= cpu_types_pkg::run;
                cpu_types_pkg::run:
                begin
                    if (is_store)
                    begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= cpu_types_pkg::store_wait;
                    end
                    else if (pop && (instr.opcode == cpu_types_pkg::op_halt))
                        state <= cpu_types_pkg::halted;
                end
                cpu_types_pkg::store_wait:
                begin
                    aw_valid <= aw_left;
                    w_valid  <= w_left;
                    if (!aw_left && !w_left)
                        state <= cpu_types_pkg::resp_wait;
                end
                cpu_types_pkg::resp_wait:
                    if (b.valid)
                        state <= cpu_types_pkg::run;
                default:
                    state <= state;
            endcase
        end
    end

    // store payload, held while the valids are up
    always_ff @(posedge clock)
    begin
        if (is_store)
        begin
            store_addr <= cpu_types_pkg::word_t'(instr.value) << 2;
            store_data <= src_a;
        end
    end

    assign aw.valid = aw_valid;
    assign aw.addr  = store_addr;
    assign w.valid  = w_valid;
    assign w.data   = store_data;
    assign w.strb   = '1;
    assign bready   = (state == cpu_types_pkg::resp_wait);
    assign halted   = (state == cpu_types_pkg::halted);

endmodule

//--- instr_queue.sv
`timescale 1ns/1ps
`include "tiny_cpu_cfg.svh"

module instr_queue
#(
    parameter int DEPTH = `TINY_CPU_QDEPTH
)
(
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 push,
    input  cpu_types_pkg::word_t push_word,
    input  logic                 pop,
    input  logic                 flush,
    output cpu_types_pkg::word_t head_word,
    output logic                 full,
    output logic                 empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    cpu_types_pkg::word_t mem [DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          count;
    logic                 wr_en;
    logic                 rd_en;

    assign full      = (count == (AW+1)'(DEPTH));
    assign empty     = (count == '0);
    assign head_word = mem[rd_ptr];

    // flush wins over both ends
    assign wr_en = push && !full && !flush;
    assign rd_en = pop && !empty && !flush;

    always_ff @(posedge clock)
    begin
        if (wr_en)
            mem[wr_ptr] <= push_word;
    end

    // pointers wrap on their own since DEPTH is a power of two
    // a single entry keeps both pointers at zero
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (DEPTH > 1) ? wr_ptr + 1'b1 : '0;
            if (rd_en)
                rd_ptr <= (DEPTH > 1) ? rd_ptr + 1'b1 : '0;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps
`include "tiny_cpu_cfg.svh"

module fetch_unit
(
    input  logic                 clock,
    input  logic                 arst_n,
    output bus_pkg::axil_addr_t  ar,
    input  logic                 arready,
    input  bus_pkg::axil_rdata_t r,
    output logic                 rready,
    output logic                 push,
    output cpu_types_pkg::word_t push_word,
    input  logic                 full,
    input  logic                 redirect_valid,
    input  cpu_types_pkg::word_t redirect_pc
);

    // pc is the word address of the next request to prepare
    cpu_types_pkg::word_t pc;
    cpu_types_pkg::word_t next_pc;
    cpu_types_pkg::word_t ar_addr;
    logic                 armed;
    logic                 outstanding;
    logic                 stale;
    logic                 ar_fire;
    logic                 r_fire;
    logic                 arm_now;
    logic                 retarget;

    // armed and outstanding never overlap, so full cannot rise under a raised valid
    assign ar.valid = armed && !full;
    assign ar.addr  = ar_addr;
    assign rready   = outstanding;

    assign ar_fire  = ar.valid && arready;
    assign r_fire   = outstanding && r.valid;
    // first request after reset, then one per returned response
    assign arm_now  = (!armed && !outstanding) || r_fire;
    // a request still hidden behind a full queue can simply be re-aimed
    assign retarget = armed && full && redirect_valid;
    assign next_pc  = redirect_valid ? redirect_pc : pc;

    assign push      = r_fire && !stale;
    assign push_word = r.data;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc          <= `TINY_CPU_RESET_PC;
            armed       <= 1'b0;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end
        else
        begin
            if (arm_now || retarget)
                pc <= next_pc + 1'b1;
            else if (redirect_valid)
                pc <= redirect_pc;

            if (arm_now)
                armed <= 1'b1;
            else if (ar_fire)
                armed <= 1'b0;

            if (ar_fire)
                outstanding <= 1'b1;
            else if (r_fire)
                outstanding <= 1'b0;

            // a visible or accepted request now fetches from the old path
            if (redirect_valid && ((outstanding && !r_fire) || ar.valid))
                stale <= 1'b1;
            else if (r_fire)
                stale <= 1'b0;
        end
    end

    // byte address of the prepared request
    always_ff @(posedge clock)
    begin
        if (arm_now || retarget)
            ar_addr <= {next_pc[`TINY_CPU_XLEN-3:0], 2'b00};
    end

endmodule

//--- bus_pkg.sv
`include "tiny_cpu_cfg.svh"

package bus_pkg;

    // used for both the read and the write address channel
    typedef struct packed {
        logic                      valid;
        logic [`TINY_CPU_XLEN-1:0] addr;
    } axil_addr_t;

    typedef struct packed {
        logic                        valid;
        logic [`TINY_CPU_XLEN-1:0]   data;
        logic [`TINY_CPU_XLEN/8-1:0] strb;
    } axil_wdata_t;

    typedef struct packed {
        logic                      valid;
        logic [`TINY_CPU_XLEN-1:0] data;
        logic [1:0]                resp;
    } axil_rdata_t;

    // write response, resp is not interpreted by the core
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_resp_t;

endpackage

//--- cpu_types_pkg.sv
`include "tiny_cpu_cfg.svh"

package cpu_types_pkg;

    typedef logic [`TINY_CPU_XLEN-1:0]          word_t;
    typedef logic [$clog2(`TINY_CPU_NREGS)-1:0] reg_idx_t;
    typedef logic [5:0]                         opcode_t;
    typedef logic [15:0]                        imm_t;

    // instruction word, msb first
    typedef struct packed {
        imm_t     value;
        logic     highlow;
        reg_idx_t dst;
        reg_idx_t srcb;
        reg_idx_t srca;
        opcode_t  opcode;
    } instr_t;

    localparam opcode_t op_nop    = 6'd0;
    localparam opcode_t op_add    = 6'd1;
    localparam opcode_t op_sub    = 6'd2;
    localparam opcode_t op_and    = 6'd3;
    localparam opcode_t op_or     = 6'd4;
    localparam opcode_t op_xor    = 6'd5;
    localparam opcode_t op_ldh    = 6'd6;
    localparam opcode_t op_store  = 6'd7;
    localparam opcode_t op_branch = 6'd8;
    localparam opcode_t op_jump   = 6'd9;
    localparam opcode_t op_halt   = 6'd10;

    typedef enum logic [2:0] {
        idle,
        run,
        store_wait,
        resp_wait,
        halted
    } exec_state_e;

endpackage

//--- tiny_cpu_cfg.svh
`ifndef TINY_CPU_CFG_SVH
`define TINY_CPU_CFG_SVH

// data and address width, one word
`define TINY_CPU_XLEN     32

// general registers, each with its own zero flag
`define TINY_CPU_NREGS    8

// instruction queue entries, a power of two of at least 2
`define TINY_CPU_QDEPTH   4

// word address of the first fetch after reset
`define TINY_CPU_RESET_PC 32'h0000_0000

`endif
